/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM       ?= $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

$(SIM): $(FLIST) $(wildcard verilog/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

test: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

/* tb/tb_rv_model.svh */
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// architectural register file, updated only by retired instructions
word_t ref_regs [32];

function automatic op_t ref_decode(input word_t ins, output word_t imm);
    logic [6:0] f7;
    logic [2:0] f3;
    op_t        op;
    f7  = ins[31:25];
    f3  = ins[14:12];
    op  = op_nop;
    imm = '0;
    case (ins[6:0])
        opc_op: begin
            case ({f7, f3})
                {7'h00, 3'd0}: op = op_add;
                {7'h20, 3'd0}: op = op_sub;
                {7'h00, 3'd1}: op = op_sll;
                {7'h00, 3'd2}: op = op_slt;
                {7'h00, 3'd3}: op = op_sltu;
                {7'h00, 3'd4}: op = op_xor;
                {7'h00, 3'd5}: op = op_srl;
                {7'h20, 3'd5}: op = op_sra;
                {7'h00, 3'd6}: op = op_or;
                {7'h00, 3'd7}: op = op_and;
                default:       op = op_nop;
            endcase
        end
        opc_op_imm: begin
            imm = {{20{ins[31]}}, ins[31:20]};
            case (f3)
                3'd0:    op = op_addi;
                3'd2:    op = op_slti;
                3'd3:    op = op_sltiu;
                3'd4:    op = op_xori;
                3'd6:    op = op_ori;
                3'd7:    op = op_andi;
                3'd1:    op = (f7 == 7'h00) ? op_slli : op_nop;
                default: op = (f7 == 7'h00) ? op_srli : (f7 == 7'h20) ? op_srai : op_nop;
            endcase
        end
        opc_lui: begin
            imm = {ins[31:12], 12'b0};
            op  = op_lui;
        end
        opc_auipc: begin
            imm = {ins[31:12], 12'b0};
            op  = op_auipc;
        end
        opc_branch: begin
            imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            case (f3)
                3'd0:    op = op_beq;
                3'd1:    op = op_bne;
                3'd4:    op = op_blt;
                3'd5:    op = op_bge;
                3'd6:    op = op_bltu;
                3'd7:    op = op_bgeu;
                default: op = op_nop;
            endcase
        end
        opc_jal: begin
            imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            op  = op_jal;
        end
        opc_jalr: begin
            imm = {{20{ins[31]}}, ins[31:20]};
            op  = (f3 == 3'd0) ? op_jalr : op_nop;
        end
        default: op = op_nop;
    endcase
    return op;
endfunction

// executes one instruction against ref_regs, in program order
function automatic void ref_execute(input word_t ins, input word_t ipc,
                                    output reg_idx_t rd, output word_t data,
                                    output logic jmp, output word_t jpc);
    op_t   op;
    word_t imm;
    word_t a;
    word_t b;
    logic  t;
    op   = ref_decode(ins, imm);
    a    = ref_regs[ins[19:15]];
    b    = ref_regs[ins[24:20]];
    rd   = ins[11:7];
    data = '0;
    jmp  = 1'b0;
    jpc  = '0;
    t    = 1'b0;
    case (op)
        op_add:   data = a + b;
        op_addi:  data = a + imm;
        op_sub:   data = a - b;
        op_and:   data = a & b;
        op_andi:  data = a & imm;
        op_or:    data = a | b;
        op_ori:   data = a | imm;
        op_xor:   data = a ^ b;
        op_xori:  data = a ^ imm;
        op_sll:   data = a << b[4:0];
        op_slli:  data = a << imm[4:0];
        op_srl:   data = a >> b[4:0];
        op_srli:  data = a >> imm[4:0];
        op_sra:   data = $signed(a) >>> b[4:0];
        op_srai:  data = $signed(a) >>> imm[4:0];
        op_slt:   data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        op_slti:  data = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
        op_sltu:  data = (a < b) ? 32'd1 : 32'd0;
        op_sltiu: data = (a < imm) ? 32'd1 : 32'd0;
        op_lui:   data = imm;
        op_auipc: data = ipc + imm;
        op_jal: begin
            data = ipc + 32'd4;
            jmp  = 1'b1;
            jpc  = ipc + imm;
        end
        op_jalr: begin
            data = ipc + 32'd4;
            jmp  = 1'b1;
            jpc  = (a + imm) & ~32'd1;
        end
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
            case (op)
                op_beq:  t = (a == b);
                op_bne:  t = (a != b);
                op_blt:  t = ($signed(a) < $signed(b));
                op_bge:  t = ($signed(a) >= $signed(b));
                op_bltu: t = (a < b);
                default: t = (a >= b);
            endcase
            rd  = '0;
            jmp = t;
            jpc = t ? ipc + imm : '0;
        end
        default: rd = '0;   // unsupported encodings retire as no-ops
    endcase
    if (rd != '0)
        ref_regs[rd] = data;
endfunction

`endif

/* tb/tb_rv_core.sv */
module tb_rv_core import rv_pkg::*; ();

    localparam int n_dir   = 450;   // rough count of directed instructions
    localparam int n_rand  = 200;
    localparam int n_bp    = 200;
    localparam int n_flush = 200;
    // stalls and gaps cost up to about three cycles per instruction
    localparam int max_cycles = 2 * (n_dir + n_rand + 3 * n_bp + 3 * n_flush);

    logic     CLK;
    logic     rst;
    logic     flush;
    logic     in_valid;
    logic     in_ready;
    word_t    instr;
    word_t    pc;
    logic     out_valid;
    logic     out_ready;
    reg_idx_t out_rd;
    word_t    out_data;
    logic     out_jmp_taken;
    word_t    out_jmp_pc;

    integer   seed = 838;
    int       val_errors = 0;
    int       proto_errors = 0;
    int       cycles = 0;
    int       retired = 0;
    string    test_name = "reset";
    bit       bp_on = 1'b0;
    word_t    next_pc;
    word_t    q_instr [$];   // accepted, not yet retired
    word_t    q_pc [$];

    logic [6:0] r_f7 [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00,
                             7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
    logic [2:0] r_f3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    logic [2:0] i_f3 [6]  = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
    logic [2:0] b_f3 [6]  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    rv_core_top dut_i (
        .CLK           (CLK),
        .rst           (rst),
        .flush         (flush),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .instr         (instr),
        .pc            (pc),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_rd        (out_rd),
        .out_data      (out_data),
        .out_jmp_taken (out_jmp_taken),
        .out_jmp_pc    (out_jmp_pc)
    );

    `include "tb_rv_model.svh"

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic word_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                    input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_u(input logic [6:0] opc, input reg_idx_t rd,
                                    input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic word_t enc_b(input logic [2:0] f3, input reg_idx_t rs1,
                                    input reg_idx_t rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic word_t enc_j(input reg_idx_t rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    function automatic word_t rand_instr();
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [11:0] imm;
        int          k;
        rd  = reg_idx_t'(rnd(8));   // x0..x7 keeps dependencies dense
        rs1 = reg_idx_t'(rnd(8));
        rs2 = reg_idx_t'(rnd(8));
        imm = 12'($random(seed));
        k   = rnd(8);
        case (k)
            0, 1, 2: begin
                k = rnd(10);
                return enc_r(r_f7[k], r_f3[k], rd, rs1, rs2);
            end
            3, 4:    return enc_i(opc_op_imm, i_f3[rnd(6)], rd, rs1, imm);
            5: begin
                k = rnd(3);
                if (k == 0)
                    return enc_i(opc_op_imm, 3'd1, rd, rs1, {7'h00, imm[4:0]});
                return enc_i(opc_op_imm, 3'd5, rd, rs1, {(k == 2) ? 7'h20 : 7'h00, imm[4:0]});
            end
            6:       return enc_u((rnd(2) == 0) ? opc_lui : opc_auipc, rd, {imm, imm[7:0]});
            default: begin
                k = rnd(4);
                if (k == 0)
                    return enc_j(rd, {imm, imm[7:0], 1'b0});
                if (k == 1)
                    return enc_i(opc_jalr, 3'd0, rd, rs1, imm);
                return enc_b(b_f3[rnd(6)], rs1, rs2, {imm, 1'b0});
            end
        endcase
    endfunction

    task automatic compare_field(input string field, input word_t exp, input word_t act);
        assert (exp == act) else begin
            val_errors++;
            $display("CHECK FAILED %s %s: expected %h actual %h", test_name, field, exp, act);
        end
    endtask

    task automatic report(input string msg);
        proto_errors++;
        $display("%s: %s", test_name, msg);
    endtask

    // called just after a falling edge; returns at the falling edge after acceptance
    task automatic issue(input word_t ins);
        instr    = ins;
        pc       = next_pc;
        in_valid = 1'b1;
        do @(posedge CLK); while (!in_ready);
        next_pc = next_pc + 32'd4;
        @(negedge CLK);
    endtask

    task automatic idle(input int n);
        in_valid = 1'b0;
        repeat (n) @(negedge CLK);
    endtask

    task automatic do_flush();
        in_valid = 1'b0;
        flush    = 1'b1;
        @(negedge CLK);
        flush = 1'b0;
    endtask

    task automatic drain();
        in_valid = 1'b0;
        while (q_instr.size() != 0)
            @(negedge CLK);
        repeat (3) @(negedge CLK);   // catches stray retires
    endtask

    task automatic set_reg(input reg_idx_t rd, input word_t value);
        word_t upper;
        upper = value + 32'h800;   // addi sign-extends the low part
        issue(enc_u(opc_lui, rd, upper[31:12]));
        issue(enc_i(opc_op_imm, 3'd0, rd, rd, value[11:0]));
    endtask

    task automatic run_random(input int n, input bit bp, input bit gaps, input bit flushes);
        bp_on = bp;
        for (int i = 0; i < n; i++) begin
            if (gaps && rnd(4) == 0)
                idle(1 + rnd(2));
            if (flushes && rnd(16) == 0)
                do_flush();
            issue(rand_instr());
        end
        bp_on = 1'b0;
        drain();
    endtask

    // retire check, flush discard and acceptance, in that order per edge
    always @(posedge CLK) begin : monitor
        reg_idx_t e_rd;
        word_t    e_data;
        logic     e_jmp;
        word_t    e_jpc;
        word_t    ins;
        word_t    ipc;
        if (!rst) begin
            if (out_valid && out_ready) begin
                assert (q_instr.size() != 0)
                    else report($sformatf("retire of rd %0d with no instruction in flight",
                                          out_rd));
                if (q_instr.size() != 0) begin
                    ins = q_instr.pop_front();
                    ipc = q_pc.pop_front();
                    ref_execute(ins, ipc, e_rd, e_data, e_jmp, e_jpc);
                    compare_field("rd", {27'b0, e_rd}, {27'b0, out_rd});
                    compare_field("data", e_data, out_data);
                    compare_field("jmp_taken", {31'b0, e_jmp}, {31'b0, out_jmp_taken});
                    compare_field("jmp_pc", e_jpc, out_jmp_pc);
                    retired++;
                end
            end
            if (flush) begin
                q_instr.delete();
                q_pc.delete();
            end else if (in_valid && in_ready) begin
                q_instr.push_back(instr);
                q_pc.push_back(pc);
            end
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles in %s, %0d instructions never retired",
                     cycles, test_name, q_instr.size());
            $display("sim failed");
            $finish;
        end
    end

    // drawn at the rising edge, applied at the falling edge
    initial begin
        logic rdy;
        out_ready = 1'b1;
        forever begin
            @(posedge CLK);
            rdy = bp_on ? ($random(seed) % 3 != 0) : 1'b1;
            @(negedge CLK);
            out_ready = rdy;
        end
    end

    initial begin
        rst      = 1'b1;
        flush    = 1'b0;
        in_valid = 1'b0;
        instr    = nop_instr;
        pc       = '0;
        next_pc  = '0;
        for (int i = 0; i < 32; i++)
            ref_regs[i] = '0;
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        rst = 1'b0;

        assert (!out_valid && !out_jmp_taken) else report("out_valid or jmp flag high after reset");
        assert (in_ready) else report("in_ready low after reset");

        test_name = "latency";
        issue(enc_i(opc_op_imm, 3'd0, 5'd1, 5'd0, 12'd7));
        in_valid = 1'b0;
        assert (!out_valid) else report("result visible one edge after acceptance");
        @(negedge CLK);
        assert (!out_valid) else report("result visible before the second edge");
        @(negedge CLK);
        assert (out_valid) else report("result not visible two edges after acceptance");
        drain();

        test_name = "alu_directed";
        set_reg(5'd1, 32'h8000_0000);
        set_reg(5'd2, 32'h7fff_ffff);
        set_reg(5'd3, 32'hffff_ffff);
        set_reg(5'd4, 32'd1);
        set_reg(5'd5, 32'd31);
        set_reg(5'd6, 32'h1234_5678);
        foreach (r_f7[k]) begin
            foreach (i_f3[s2]) begin
                issue(enc_r(r_f7[k], r_f3[k], 5'd7, 5'd1, reg_idx_t'(s2)));
                issue(enc_r(r_f7[k], r_f3[k], 5'd7, 5'd2, reg_idx_t'(s2)));
                issue(enc_r(r_f7[k], r_f3[k], 5'd7, 5'd3, reg_idx_t'(s2)));
                issue(enc_r(r_f7[k], r_f3[k], 5'd7, 5'd6, reg_idx_t'(s2)));
            end
        end
        for (int s1 = 1; s1 <= 6; s1++) begin
            foreach (i_f3[k]) begin
                issue(enc_i(opc_op_imm, i_f3[k], 5'd7, reg_idx_t'(s1), 12'h000));
                issue(enc_i(opc_op_imm, i_f3[k], 5'd7, reg_idx_t'(s1), 12'h7ff));
                issue(enc_i(opc_op_imm, i_f3[k], 5'd7, reg_idx_t'(s1), 12'h800));
                issue(enc_i(opc_op_imm, i_f3[k], 5'd7, reg_idx_t'(s1), 12'hfff));
            end
            issue(enc_i(opc_op_imm, 3'd1, 5'd7, reg_idx_t'(s1), 12'h000));
            issue(enc_i(opc_op_imm, 3'd1, 5'd7, reg_idx_t'(s1), 12'h01f));
            issue(enc_i(opc_op_imm, 3'd5, 5'd7, reg_idx_t'(s1), 12'h000));
            issue(enc_i(opc_op_imm, 3'd5, 5'd7, reg_idx_t'(s1), 12'h01f));
            issue(enc_i(opc_op_imm, 3'd5, 5'd7, reg_idx_t'(s1), 12'h400));   // srai 0
            issue(enc_i(opc_op_imm, 3'd5, 5'd7, reg_idx_t'(s1), 12'h41f));   // srai 31
        end
        drain();

        test_name = "dependencies";
        run_random(n_rand, 1'b0, 1'b0, 1'b0);

        test_name = "branches";
        set_reg(5'd1, 32'd5);
        set_reg(5'd2, 32'd5);
        set_reg(5'd3, 32'hffff_ffff);
        foreach (b_f3[k]) begin
            issue(enc_b(b_f3[k], 5'd1, 5'd2, 13'h1ff8));
            issue(enc_b(b_f3[k], 5'd1, 5'd3, 13'd12));
            issue(enc_b(b_f3[k], 5'd3, 5'd1, 13'h1ff8));
        end
        issue(enc_j(5'd6, 21'd2048));
        issue(enc_j(5'd0, 21'h1ffffc));
        issue(enc_i(opc_jalr, 3'd0, 5'd6, 5'd1, 12'h000));   // odd target 5
        issue(enc_i(opc_jalr, 3'd0, 5'd7, 5'd1, 12'hffe));
        issue(enc_i(opc_jalr, 3'd0, 5'd6, 5'd3, 12'h002));
        drain();

        test_name = "backpressure";
        run_random(n_bp, 1'b1, 1'b1, 1'b0);

        test_name = "flush";
        run_random(n_flush, 1'b0, 1'b1, 1'b1);

        $display("errors: %0d value mismatches, %0d protocol errors, %0d retired",
                 val_errors, proto_errors, retired);
        if (val_errors == 0 && proto_errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* verilog/decode.sv */
module decode import rv_pkg::*; (
    input  logic     CLK,
    input  logic     rst,
    input  logic     flush,
    input  logic     hold,
    input  logic     in_valid,
    input  word_t    instr,
    input  word_t    pc,
    input  logic     we,
    input  reg_idx_t wd_idx,
    input  word_t    wd,
    dec_exe_if.src   dx
);

    logic       valid_q;
    word_t      instr_q;
    word_t      pc_q;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm_j;
    op_t        op;
    word_t      imm;
    logic       dst;

    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            valid_q <= 1'b0;
        end else if (!hold) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (!hold) begin
            instr_q <= in_valid ? instr : nop_instr;   // idle slot decodes as nop
            pc_q    <= pc;
        end
    end

    assign opcode = instr_q[6:0];
    assign funct3 = instr_q[14:12];
    assign funct7 = instr_q[31:25];

    assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_u = {instr_q[31:12], 12'b0};
    assign imm_b = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
                    instr_q[11:8], 1'b0};
    assign imm_j = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
                    instr_q[30:21], 1'b0};

    always_comb begin
        op  = op_nop;
        imm = '0;
        dst = 1'b0;
        case (opcode)
            opc_op: begin
                dst = 1'b1;
                case ({funct7, funct3})
                    {f7_base, 3'b000}: op = op_add;
                    {f7_alt,  3'b000}: op = op_sub;
                    {f7_base, 3'b001}: op = op_sll;
                    {f7_base, 3'b010}: op = op_slt;
                    {f7_base, 3'b011}: op = op_sltu;
                    {f7_base, 3'b100}: op = op_xor;
                    {f7_base, 3'b101}: op = op_srl;
                    {f7_alt,  3'b101}: op = op_sra;
                    {f7_base, 3'b110}: op = op_or;
                    {f7_base, 3'b111}: op = op_and;
                    default:           op = op_nop;
                endcase
            end
            opc_op_imm: begin
                dst = 1'b1;
                imm = imm_i;
                case (funct3)
                    3'b000: op = op_addi;
                    3'b010: op = op_slti;
                    3'b011: op = op_sltiu;
                    3'b100: op = op_xori;
                    3'b110: op = op_ori;
                    3'b111: op = op_andi;
                    3'b001: begin
                        if (funct7 == f7_base)
                            op = op_slli;
                    end
                    default: begin   // shift right
                        if (funct7 == f7_base)
                            op = op_srli;
                        else if (funct7 == f7_alt)
                            op = op_srai;
                    end
                endcase
            end
            opc_lui: begin
                dst = 1'b1;
                imm = imm_u;
                op  = op_lui;
            end
            opc_auipc: begin
                dst = 1'b1;
                imm = imm_u;
                op  = op_auipc;
            end
            opc_branch: begin
                imm = imm_b;
                case (funct3)
                    3'b000:  op = op_beq;
                    3'b001:  op = op_bne;
                    3'b100:  op = op_blt;
                    3'b101:  op = op_bge;
                    3'b110:  op = op_bltu;
                    3'b111:  op = op_bgeu;
                    default: op = op_nop;
                endcase
            end
            opc_jal: begin
                dst = 1'b1;
                imm = imm_j;
                op  = op_jal;
            end
            opc_jalr: begin
                dst = 1'b1;
                imm = imm_i;
                if (funct3 == 3'b000)
                    op = op_jalr;
            end
            default: op = op_nop;   // fence, system, csr, unknown
        endcase
    end

    reg_file rf_i (
        .CLK     (CLK),
        .rst     (rst),
        .rs1     (instr_q[19:15]),
        .rs2     (instr_q[24:20]),
        .rs1_val (dx.rs1_val),
        .rs2_val (dx.rs2_val),
        .we      (we),
        .wd_idx  (wd_idx),
        .wd      (wd)
    );

    assign dx.valid = valid_q;
    assign dx.pc    = pc_q;
    assign dx.op    = op;
    assign dx.rd    = (dst && op != op_nop) ? instr_q[11:7] : '0;
    assign dx.rs1   = instr_q[19:15];
    assign dx.rs2   = instr_q[24:20];
    assign dx.imm   = imm;

endmodule

/* verilog/execute.sv */
module execute import rv_pkg::*; (
    input  logic     CLK,
    input  logic     rst,
    input  logic     flush,
    input  logic     hold,
    dec_exe_if.snk   dx,
    exe_res_if.src   xr,
    input  reg_idx_t res_rd,
    input  word_t    res_data
);

    logic     valid_q;
    reg_idx_t rd_q;
    word_t    data_q;
    logic     jmp_q;
    word_t    jmp_pc_q;
    word_t    a;
    word_t    rs2_fwd;
    word_t    b;
    logic     use_imm;
    word_t    link;
    word_t    data;
    logic     taken;
    word_t    target;
    word_t    jmp_pc;

    // younger result first, then the one held in result, then the file
    function automatic word_t fwd(
        input reg_idx_t idx,
        input word_t    rf_val,
        input logic     ex_valid,
        input reg_idx_t ex_rd,
        input word_t    ex_data,
        input reg_idx_t rs_rd,
        input word_t    rs_data
    );
        if (idx == '0)
            return rf_val;
        if (ex_valid && ex_rd == idx)
            return ex_data;
        if (rs_rd == idx)
            return rs_data;
        return rf_val;
    endfunction

    assign a       = fwd(dx.rs1, dx.rs1_val, valid_q, rd_q, data_q, res_rd, res_data);
    assign rs2_fwd = fwd(dx.rs2, dx.rs2_val, valid_q, rd_q, data_q, res_rd, res_data);

    assign use_imm = dx.op inside {op_addi, op_slti, op_sltiu, op_xori, op_ori,
                                   op_andi, op_slli, op_srli, op_srai};
    assign b       = use_imm ? dx.imm : rs2_fwd;
    assign link    = dx.pc + 32'd4;

    always_comb begin
        data   = '0;
        taken  = 1'b0;
        target = dx.pc + dx.imm;   // branch and jal
        case (dx.op)
            op_add, op_addi:   data = a + b;
            op_sub:            data = a - b;
            op_and, op_andi:   data = a & b;
            op_or, op_ori:     data = a | b;
            op_xor, op_xori:   data = a ^ b;
            op_sll, op_slli:   data = a << b[4:0];
            op_srl, op_srli:   data = a >> b[4:0];
            op_sra, op_srai:   data = $signed(a) >>> b[4:0];
            op_slt, op_slti:   data = {31'b0, $signed(a) < $signed(b)};
            op_sltu, op_sltiu: data = {31'b0, a < b};
            op_lui:            data = dx.imm;
            op_auipc:          data = dx.pc + dx.imm;
            op_beq:            taken = (a == b);
            op_bne:            taken = (a != b);
            op_blt:            taken = ($signed(a) < $signed(b));
            op_bge:            taken = ($signed(a) >= $signed(b));
            op_bltu:           taken = (a < b);
            op_bgeu:           taken = (a >= b);
            op_jal: begin
                data  = link;
                taken = 1'b1;
            end
            op_jalr: begin
                data   = link;
                taken  = 1'b1;
                target = (a + dx.imm) & ~32'd1;
            end
            default: data = '0;
        endcase
    end

    assign jmp_pc = taken ? target : '0;   // zero when not taken

    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            valid_q <= 1'b0;
            jmp_q   <= 1'b0;
        end else if (!hold) begin
            valid_q <= dx.valid;
            jmp_q   <= dx.valid && taken;
        end
    end

    always_ff @(posedge CLK) begin
        if (!hold) begin
            rd_q     <= dx.rd;
            data_q   <= data;
            jmp_pc_q <= jmp_pc;
        end
    end

    assign xr.valid     = valid_q;
    assign xr.rd        = rd_q;
    assign xr.data      = data_q;
    assign xr.jmp_taken = jmp_q;
    assign xr.jmp_pc    = jmp_pc_q;

endmodule

/* verilog/reg_file.sv */
module reg_file import rv_pkg::*; (
    input  logic     CLK,
    input  logic     rst,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_val,
    output word_t    rs2_val,
    input  logic     we,
    input  reg_idx_t wd_idx,
    input  word_t    wd
);

    word_t regs [num_regs];

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wd_idx != '0) begin
            regs[wd_idx] <= wd;
        end
    end

    // write-through so a retiring result is seen in the same cycle
    assign rs1_val = (rs1 == '0)                ? '0 :
                     (we && wd_idx == rs1)      ? wd :
                                                  regs[rs1];

    assign rs2_val = (rs2 == '0)                ? '0 :
                     (we && wd_idx == rs2)      ? wd :
                                                  regs[rs2];

endmodule

/* verilog/result.sv */
module result import rv_pkg::*; (
    input  logic     CLK,
    input  logic     rst,
    input  logic     flush,
    exe_res_if.snk   xr,
    input  logic     out_ready,
    output logic     hold,
    output reg_idx_t res_rd,
    output word_t    res_data,
    output logic     out_valid,
    output reg_idx_t out_rd,
    output word_t    out_data,
    output logic     out_jmp_taken,
    output word_t    out_jmp_pc,
    output logic     we
);

    logic     valid_q;
    logic     jmp_q;
    reg_idx_t rd_q;
    word_t    data_q;
    word_t    jmp_pc_q;
    logic     retire;

    assign hold   = valid_q && !out_ready;   // stalls the whole pipe
    assign retire = valid_q && out_ready;

    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            valid_q <= 1'b0;
            jmp_q   <= 1'b0;
        end else if (!hold) begin
            valid_q <= xr.valid;
            jmp_q   <= xr.jmp_taken;
        end
    end

    always_ff @(posedge CLK) begin
        if (!hold) begin
            rd_q     <= xr.rd;
            data_q   <= xr.data;
            jmp_pc_q <= xr.jmp_pc;
        end
    end

    // idle slot reports x0 as the older forwarding source
    assign res_rd   = valid_q ? rd_q : '0;
    assign res_data = data_q;

    assign we = retire && rd_q != '0;

    assign out_valid     = valid_q;
    assign out_rd        = rd_q;
    assign out_data      = data_q;
    assign out_jmp_taken = jmp_q;
    assign out_jmp_pc    = jmp_pc_q;

endmodule

/* verilog/rv_core_top.sv */
module rv_core_top import rv_pkg::*; (
    input  logic     CLK,
    input  logic     rst,
    input  logic     flush,
    input  logic     in_valid,
    output logic     in_ready,
    input  word_t    instr,
    input  word_t    pc,
    output logic     out_valid,
    input  logic     out_ready,
    output reg_idx_t out_rd,
    output word_t    out_data,
    output logic     out_jmp_taken,
    output word_t    out_jmp_pc
);

    logic     hold;
    logic     we;
    reg_idx_t res_rd;
    word_t    res_data;

    dec_exe_if dx_if ();
    exe_res_if xr_if ();

    assign in_ready = !hold;

    decode decode_i (
        .CLK      (CLK),
        .rst      (rst),
        .flush    (flush),
        .hold     (hold),
        .in_valid (in_valid),
        .instr    (instr),
        .pc       (pc),
        .we       (we),
        .wd_idx   (out_rd),   // write-back of the retiring result
        .wd       (out_data),
        .dx       (dx_if)
    );

    execute execute_i (
        .CLK      (CLK),
        .rst      (rst),
        .flush    (flush),
        .hold     (hold),
        .dx       (dx_if),
        .xr       (xr_if),
        .res_rd   (res_rd),
        .res_data (res_data)
    );

    result result_i (
        .CLK           (CLK),
        .rst           (rst),
        .flush         (flush),
        .xr            (xr_if),
        .out_ready     (out_ready),
        .hold          (hold),
        .res_rd        (res_rd),
        .res_data      (res_data),
        .out_valid     (out_valid),
        .out_rd        (out_rd),
        .out_data      (out_data),
        .out_jmp_taken (out_jmp_taken),
        .out_jmp_pc    (out_jmp_pc),
        .we            (we)
    );

endmodule

/* verilog/rv_pkg.sv */
package rv_pkg;

    localparam int xlen     = 32;
    localparam int num_regs = 32;

    typedef logic [xlen-1:0]               word_t;
    typedef logic [$clog2(num_regs)-1:0]   reg_idx_t;

    // register-register, register-immediate, upper, branch, jump
    typedef enum logic [4:0] {
        op_add, op_sub, op_and, op_or, op_xor,
        op_sll, op_srl, op_sra, op_slt, op_sltu,
        op_addi, op_andi, op_ori, op_xori,
        op_slli, op_srli, op_srai, op_slti, op_sltiu,
        op_lui, op_auipc,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_jal, op_jalr,
        op_nop
    } op_t;

    // major opcodes
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;   // sub, sra, srai

    localparam word_t nop_instr = 32'h0000_0013;   // addi x0, x0, 0

endpackage

/* verilog/rv_stage_if.sv */
interface dec_exe_if import rv_pkg::*; ();
    logic     valid;
    word_t    pc;
    op_t      op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    imm;   // already sign extended

    modport src (output valid, pc, op, rd, rs1, rs2, rs1_val, rs2_val, imm);
    modport snk (input valid, pc, op, rd, rs1, rs2, rs1_val, rs2_val, imm);
endinterface

interface exe_res_if import rv_pkg::*; ();
    logic     valid;
    reg_idx_t rd;
    word_t    data;
    logic     jmp_taken;
    word_t    jmp_pc;

    modport src (output valid, rd, data, jmp_taken, jmp_pc);
    modport snk (input valid, rd, data, jmp_taken, jmp_pc);
endinterface

/* vlog.f */
+incdir+tb
verilog/rv_pkg.sv
verilog/rv_stage_if.sv
verilog/reg_file.sv
verilog/decode.sv
verilog/execute.sv
verilog/result.sv
verilog/rv_core_top.sv
tb/tb_rv_core.sv
